//--- Bender.yml
package:
  name: core_controller

sources:
  - ctrl_pkg.sv
  - fwd_match_if.sv
  - ctrl_fsm.sv
  - hazard_unit.sv
  - operand_fwd_unit.sv
  - core_controller.sv
  - target: test
    files:
      - tb_core_controller.sv

//--- controller_testdata.txt
# ctl = fe iv ill ecall ebrk mret fencei csr br id_ready ex_valid, then jump prv ld(req we_ex) ex_is
# exp = req first_fetch pc_set halt_if halt_id save mret_rst ld_stall jr_stall deassert_we, pc_mux cause
10000000000 0 3 00 000 0000000001 0 00
10000000000 0 3 00 000 0000000001 0 00
10000000000 0 3 00 000 1010000001 0 00
10000000000 0 3 00 000 1100000001 0 00
10000000010 0 3 00 000 1100000001 0 00
11000000010 0 3 00 000 1000000000 0 00
11100000010 0 3 00 000 1001110001 0 02
10000000000 0 3 00 000 1001100001 0 00
10000000000 0 3 00 000 1001100001 0 00
10000000001 0 3 00 000 1001100001 0 00
10000000000 0 3 00 000 1011100001 4 00
11010000010 0 0 00 000 1001110000 0 08
10010000001 0 0 00 000 1001100001 0 00
10010000000 0 0 00 000 1011100001 4 00
11010000010 0 3 00 000 1001110000 0 0b
10010000000 0 3 00 000 1001100001 0 00
10010000001 0 3 00 000 1001100001 0 00
10010000000 0 3 00 000 1011100001 4 00
11000100010 0 3 00 000 1001100000 0 00
10000100001 0 3 00 000 1001100001 0 00
10000100000 0 3 00 000 1001101001 0 00
10000000000 0 3 00 000 1010000001 5 00
11000010010 0 3 00 000 1001100000 0 00
10000010001 0 3 00 000 1001100001 0 00
10000010000 0 3 00 000 1011100001 1 00
11000000110 0 3 00 000 1010000001 3 00
11000000000 2 3 01 001 1000000011 2 00
11000000000 2 3 01 001 1000000011 2 00
11000000000 2 3 00 000 1010000000 2 00
11000000000 2 3 00 000 1000000000 2 00
11000000010 2 3 00 000 1000000000 2 00
11000000010 0 3 11 010 1000000101 0 00

//--- core_controller.sv
////////////////////
// controller top: fsm, hazard unit and operand forwarding
////////////////////

module core_controller import ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       illegal_insn_i,
  input  logic       ecall_insn_i,
  input  logic       ebrk_insn_i,
  input  logic       mret_insn_i,
  input  logic       fencei_insn_i,
  input  logic       csr_status_i,
  input  logic       branch_taken_ex_i,
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  jump_kind_e jump_in_dec_i,
  input  priv_lvl_e  priv_lvl_i,
  input  logic       data_req_ex_i,
  input  logic       regfile_we_id_i,
  input  reg_addr_t  regfile_waddr_ex_i,
  input  reg_addr_t  regfile_waddr_id_i,
  input  logic       data_misaligned_i,
  input  logic       mult_multicycle_i,
  input  logic       regfile_we_ex_i,
  input  logic       regfile_we_wb_i,
  input  logic       regfile_alu_we_fw_i,
  input  logic       wb_ready_i,
  input  op_match_t  reg_d_ex_is_i,
  input  op_match_t  reg_d_wb_is_i,
  input  op_match_t  reg_d_alu_is_i,
  output logic       instr_req_o,
  output logic       ctrl_busy_o,
  output logic       first_fetch_o,
  output logic       pc_set_o,
  output pc_sel_e    pc_mux_o,
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       csr_save_id_o,
  output logic       csr_save_cause_o,
  output exc_cause_t csr_cause_o,
  output logic       csr_restore_mret_o,
  output logic       load_stall_o,
  output logic       deassert_we_o,
  output logic       misaligned_stall_o,
  output logic       jr_stall_o,
  output fwd_sel_e   operand_a_fwd_o,
  output fwd_sel_e   operand_b_fwd_o,
  output fwd_sel_e   operand_c_fwd_o
);

  logic issue;
  logic jr_stall;

  ////////////////////
  // forwarding bundle
  ////////////////////
  fwd_match_if fwd_bus ();

  assign fwd_bus.we_ex     = regfile_we_ex_i;
  assign fwd_bus.we_wb     = regfile_we_wb_i;
  assign fwd_bus.alu_we_fw = regfile_alu_we_fw_i;
  assign fwd_bus.wb_ready  = wb_ready_i;
  assign fwd_bus.ex_is     = reg_d_ex_is_i;
  assign fwd_bus.wb_is     = reg_d_wb_is_i;
  assign fwd_bus.alu_is    = reg_d_alu_is_i;

  ctrl_fsm u_ctrl_fsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .instr_valid_i      (instr_valid_i),
    .illegal_insn_i     (illegal_insn_i),
    .ecall_insn_i       (ecall_insn_i),
    .ebrk_insn_i        (ebrk_insn_i),
    .mret_insn_i        (mret_insn_i),
    .fencei_insn_i      (fencei_insn_i),
    .csr_status_i       (csr_status_i),
    .branch_taken_ex_i  (branch_taken_ex_i),
    .id_ready_i         (id_ready_i),
    .ex_valid_i         (ex_valid_i),
    .jump_in_dec_i      (jump_in_dec_i),
    .priv_lvl_i         (priv_lvl_i),
    .jr_stall_i         (jr_stall),
    .instr_req_o        (instr_req_o),
    .ctrl_busy_o        (ctrl_busy_o),
    .first_fetch_o      (first_fetch_o),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .halt_if_o          (halt_if_o),
    .halt_id_o          (halt_id_o),
    .csr_save_id_o      (csr_save_id_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_cause_o        (csr_cause_o),
    .csr_restore_mret_o (csr_restore_mret_o),
    .issue_o            (issue)
  );

  hazard_unit u_hazard_unit (
    .fwd                (fwd_bus),
    .data_req_ex_i      (data_req_ex_i),
    .regfile_we_id_i    (regfile_we_id_i),
    .issue_i            (issue),
    .regfile_waddr_ex_i (regfile_waddr_ex_i),
    .regfile_waddr_id_i (regfile_waddr_id_i),
    .jump_in_dec_i      (jump_in_dec_i),
    .load_stall_o       (load_stall_o),
    .jr_stall_o         (jr_stall),
    .deassert_we_o      (deassert_we_o)
  );

  operand_fwd_unit u_operand_fwd_unit (
    .fwd               (fwd_bus),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .operand_a_fwd_o   (operand_a_fwd_o),
    .operand_b_fwd_o   (operand_b_fwd_o),
    .operand_c_fwd_o   (operand_c_fwd_o)
  );

  assign jr_stall_o = jr_stall;

  // misaligned access stalls id for its second half
  assign misaligned_stall_o = data_misaligned_i;

endmodule

//--- ctrl_fsm.sv
////////////////////
// main controller fsm: boot, decode redirects, flush and exceptions
////////////////////

module ctrl_fsm import ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       illegal_insn_i,
  input  logic       ecall_insn_i,
  input  logic       ebrk_insn_i,
  input  logic       mret_insn_i,
  input  logic       fencei_insn_i,
  input  logic       csr_status_i,
  input  logic       branch_taken_ex_i,
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  jump_kind_e jump_in_dec_i,
  input  priv_lvl_e  priv_lvl_i,
  input  logic       jr_stall_i,
  output logic       instr_req_o,
  output logic       ctrl_busy_o,
  output logic       first_fetch_o,
  output logic       pc_set_o,
  output pc_sel_e    pc_mux_o,
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       csr_save_id_o,
  output logic       csr_save_cause_o,
  output exc_cause_t csr_cause_o,
  output logic       csr_restore_mret_o,
  output logic       issue_o
);

  ctrl_state_e state_q, state_d;
  logic        jump_done_q, jump_done_d;
  logic        illegal_q, illegal_d;
  logic        jump_in_dec;

  // unconditional jumps resolve in decode, conditional ones in ex
  assign jump_in_dec = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  ////////////////////
  // next state and outputs
  ////////////////////
  always_comb begin
    state_d            = state_q;
    jump_done_d        = jump_done_q;
    illegal_d          = illegal_q;
    instr_req_o        = 1'b1;
    ctrl_busy_o        = 1'b1;
    first_fetch_o      = 1'b0;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    halt_if_o          = 1'b0;
    halt_id_o          = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_cause_o        = '0;
    csr_restore_mret_o = 1'b0;
    issue_o            = 1'b0;

    unique case (state_q)
      // idle until fetching is enabled
      RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load boot address into the fetch pc
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // wait for the first instruction to reach id
      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_i) begin
          state_d = DECODE;
        end
      end

      DECODE: begin
        if (branch_taken_ex_i) begin
          // taken branch in ex wins over anything in id
          pc_set_o = 1'b1;
          pc_mux_o = PC_BRANCH;
        end else if (instr_valid_i) begin
          if (illegal_insn_i) begin
            halt_if_o        = 1'b1;
            halt_id_o        = 1'b1;
            csr_save_id_o    = 1'b1;
            csr_save_cause_o = 1'b1;
            csr_cause_o      = EXC_CAUSE_ILLEGAL_INSN;
            illegal_d        = 1'b1;
            state_d          = FLUSH_EX;
          end else begin
            issue_o = 1'b1;
            unique case (1'b1)
              jump_in_dec: begin
                pc_mux_o = PC_JUMP;
                // redirect once, after the target register is available
                if (!jr_stall_i && !jump_done_q) begin
                  pc_set_o    = 1'b1;
                  jump_done_d = 1'b1;
                end
              end
              ebrk_insn_i: begin
                halt_if_o        = 1'b1;
                halt_id_o        = 1'b1;
                csr_save_id_o    = 1'b1;
                csr_save_cause_o = 1'b1;
                csr_cause_o      = EXC_CAUSE_BREAKPOINT;
                state_d          = FLUSH_EX;
              end
              ecall_insn_i: begin
                halt_if_o        = 1'b1;
                halt_id_o        = 1'b1;
                csr_save_id_o    = 1'b1;
                csr_save_cause_o = 1'b1;
                csr_cause_o      = (priv_lvl_i == PRIV_LVL_U) ? EXC_CAUSE_ECALL_UMODE
                                                              : EXC_CAUSE_ECALL_MMODE;
                state_d          = FLUSH_EX;
              end
              fencei_insn_i, mret_insn_i: begin
                halt_if_o = 1'b1;
                halt_id_o = 1'b1;
                state_d   = FLUSH_EX;
              end
              csr_status_i: begin
                // hold fetch until the csr access leaves id
                halt_if_o = 1'b1;
                state_d   = id_ready_i ? FLUSH_EX : DECODE;
              end
              default: ;
            endcase
          end
        end
      end

      // drain ex before touching csr state
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // pick the redirect from the held decoder flags
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        state_d   = DECODE;
        if (illegal_q) begin
          pc_set_o  = 1'b1;
          pc_mux_o  = PC_EXCEPTION;
          illegal_d = 1'b0;
        end else begin
          unique case (1'b1)
            ebrk_insn_i, ecall_insn_i: begin
              pc_set_o = 1'b1;
              pc_mux_o = PC_EXCEPTION;
            end
            mret_insn_i: begin
              csr_restore_mret_o = 1'b1;
              state_d            = XRET_JUMP;
            end
            fencei_insn_i: begin
              // refetch the instruction after fence.i
              pc_set_o = 1'b1;
              pc_mux_o = PC_FENCEI;
            end
            default: ;
          endcase
        end
      end

      // mepc is restored, jump to it
      XRET_JUMP: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_MRET;
        state_d  = DECODE;
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
      illegal_q   <= 1'b0;
    end else begin
      state_q     <= state_d;
      // cleared once the jump leaves id
      jump_done_q <= jump_done_d & ~id_ready_i;
      illegal_q   <= illegal_d;
    end
  end

endmodule

//--- ctrl_pkg.sv
////////////////////
// controller state, pc select, forwarding select and cause encodings
////////////////////

package ctrl_pkg;

  // controller fsm states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB,
    XRET_JUMP
  } ctrl_state_e;

  // fetch pc source, encoding matches the prefetcher mux
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101
  } pc_sel_e;

  // operand source for the id stage muxes
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  // jump class from the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef logic [5:0] exc_cause_t;
  typedef logic [5:0] reg_addr_t;
  // one flag per source operand
  typedef logic [2:0] op_match_t;

  // bit positions inside op_match_t
  localparam int unsigned OP_A = 0;
  localparam int unsigned OP_B = 1;
  localparam int unsigned OP_C = 2;

  // synchronous exception causes
  localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN = 6'd2;
  localparam exc_cause_t EXC_CAUSE_BREAKPOINT   = 6'd3;
  localparam exc_cause_t EXC_CAUSE_ECALL_UMODE  = 6'd8;
  localparam exc_cause_t EXC_CAUSE_ECALL_MMODE  = 6'd11;

endpackage

//--- flist.f
ctrl_pkg.sv
fwd_match_if.sv
ctrl_fsm.sv
hazard_unit.sv
operand_fwd_unit.sv
core_controller.sv
tb_core_controller.sv

//--- fwd_match_if.sv
////////////////////
// register match and write enable bundle for hazard and forwarding
////////////////////

interface fwd_match_if import ctrl_pkg::*; ();

  // write enables of the producing stages
  logic      we_ex;
  logic      we_wb;
  logic      alu_we_fw;
  // wb stage can accept a result
  logic      wb_ready;

  // decoded source operands matching a pending destination
  op_match_t ex_is;
  op_match_t wb_is;
  op_match_t alu_is;

  // filled from the top level ports
  modport src (
    output we_ex, we_wb, alu_we_fw, wb_ready,
    output ex_is, wb_is, alu_is
  );

  // read by hazard and forwarding units
  modport sink (
    input we_ex, we_wb, alu_we_fw, wb_ready,
    input ex_is, wb_is, alu_is
  );

endinterface

//--- hazard_unit.sv
////////////////////
// load-use and jump-register stalls, write enable deassertion
////////////////////

module hazard_unit import ctrl_pkg::*; (
  fwd_match_if.sink fwd,
  input  logic       data_req_ex_i,
  input  logic       regfile_we_id_i,
  input  logic       issue_i,
  input  reg_addr_t  regfile_waddr_ex_i,
  input  reg_addr_t  regfile_waddr_id_i,
  input  jump_kind_e jump_in_dec_i,
  output logic       load_stall_o,
  output logic       jr_stall_o,
  output logic       deassert_we_o
);

  logic producer_pending;
  logic waddr_hit;
  logic jr_src_busy;

  // load in ex, or a result stuck in wb
  assign producer_pending = (data_req_ex_i & fwd.we_ex) | (~fwd.wb_ready & fwd.we_wb);

  // issued instruction writes the same register as the pending producer
  assign waddr_hit = issue_i & regfile_we_id_i & (regfile_waddr_ex_i == regfile_waddr_id_i);

  assign load_stall_o = producer_pending & ((|fwd.ex_is) | waddr_hit);

  ////////////////////
  // jump register
  ////////////////////

  // jalr target needs operand a, which is not forwarded to the pc
  assign jr_src_busy = (fwd.we_wb & fwd.wb_is[OP_A]) |
                       (fwd.we_ex & fwd.ex_is[OP_A]) |
                       (fwd.alu_we_fw & fwd.alu_is[OP_A]);

  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & jr_src_busy;

  // no register write for anything not issued or stalled
  assign deassert_we_o = ~issue_i | load_stall_o | jr_stall_o;

endmodule

//--- operand_fwd_unit.sv
////////////////////
// forwarding mux select for operands a, b and c
////////////////////

module operand_fwd_unit import ctrl_pkg::*; (
  fwd_match_if.sink fwd,
  input  logic     data_misaligned_i,
  input  logic     mult_multicycle_i,
  output fwd_sel_e operand_a_fwd_o,
  output fwd_sel_e operand_b_fwd_o,
  output fwd_sel_e operand_c_fwd_o
);

  fwd_sel_e sel [3];

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      sel[i] = SEL_REGFILE;
      // wb result first, younger ex result takes precedence
      if (fwd.we_wb && fwd.wb_is[i]) begin
        sel[i] = SEL_FW_WB;
      end
      if (fwd.alu_we_fw && fwd.alu_is[i]) begin
        sel[i] = SEL_FW_EX;
      end
    end

    // second half of a misaligned access reuses the ex address
    if (data_misaligned_i) begin
      sel[OP_A] = SEL_FW_EX;
      sel[OP_B] = SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multiplier keeps its partial result on operand c
      sel[OP_C] = SEL_FW_EX;
    end
  end

  assign operand_a_fwd_o = sel[OP_A];
  assign operand_b_fwd_o = sel[OP_B];
  assign operand_c_fwd_o = sel[OP_C];

endmodule

//--- tb_core_controller.sv
////////////////////
// testbench for the core controller: vector file replay and forwarding sweep
////////////////////

module tb_core_controller import ctrl_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // cycle limits for each wait
  localparam int RST_LIMIT = 10;
  localparam int VEC_LIMIT = 100;
  localparam int SWEEP_N   = 200;

  logic       clk;
  logic       rst_n;
  logic       fetch_enable_i, instr_valid_i, illegal_insn_i, ecall_insn_i;
  logic       ebrk_insn_i, mret_insn_i, fencei_insn_i, csr_status_i;
  logic       branch_taken_ex_i, id_ready_i, ex_valid_i;
  jump_kind_e jump_in_dec_i;
  priv_lvl_e  priv_lvl_i;
  logic       data_req_ex_i, regfile_we_id_i, data_misaligned_i, mult_multicycle_i;
  reg_addr_t  regfile_waddr_ex_i, regfile_waddr_id_i;
  logic       regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i, wb_ready_i;
  op_match_t  reg_d_ex_is_i, reg_d_wb_is_i, reg_d_alu_is_i;
  logic       instr_req_o, ctrl_busy_o, first_fetch_o, pc_set_o;
  pc_sel_e    pc_mux_o;
  logic       halt_if_o, halt_id_o, csr_save_id_o, csr_save_cause_o;
  exc_cause_t csr_cause_o;
  logic       csr_restore_mret_o, load_stall_o, deassert_we_o;
  logic       misaligned_stall_o, jr_stall_o;
  fwd_sel_e   operand_a_fwd_o, operand_b_fwd_o, operand_c_fwd_o;

  int          errors;
  int          checks;
  int          timeouts;
  logic [31:0] rnd_state;

  core_controller DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release off the clock edges, after 3 cycles
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
  end

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // quiet pipeline: nothing valid, wb accepting, machine mode
  task automatic set_idle_inputs();
    {fetch_enable_i, instr_valid_i, illegal_insn_i, ecall_insn_i} = '0;
    {ebrk_insn_i, mret_insn_i, fencei_insn_i, csr_status_i} = '0;
    {branch_taken_ex_i, id_ready_i, ex_valid_i} = '0;
    jump_in_dec_i = BRANCH_NONE;
    priv_lvl_i    = PRIV_LVL_M;
    {data_req_ex_i, regfile_we_id_i, data_misaligned_i, mult_multicycle_i} = '0;
    regfile_waddr_ex_i = '0;
    regfile_waddr_id_i = '0;
    {regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i} = '0;
    wb_ready_i     = 1'b1;
    reg_d_ex_is_i  = '0;
    reg_d_wb_is_i  = '0;
    reg_d_alu_is_i = '0;
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n >= RST_LIMIT) begin
        $display("reset did not release within %0d cycles", RST_LIMIT);
        timeouts++;
        finish_run();
      end
      @(negedge clk);
      n++;
    end
  endtask

  ////////////////////
  // vector file replay
  ////////////////////
  task automatic run_vectors();
    int          fd;
    int          n;
    int          cycles;
    string       line;
    logic [10:0] ctl;
    int          jmp;
    int          prv;
    logic [1:0]  ld;
    logic [2:0]  exis;
    logic [9:0]  f;
    int          exp_pm;
    logic [7:0]  exp_cau;
    fd = $fopen("controller_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open controller_testdata.txt");
      errors++;
      finish_run();
    end
    cycles = 0;
    while (!$feof(fd)) begin
      if (cycles >= VEC_LIMIT) begin
        $display("vector file did not end within %0d cycles", VEC_LIMIT);
        timeouts++;
        finish_run();
      end
      line = "";
      void'($fgets(line, fd));
      // skip blank and comment lines
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%b %d %d %b %b %b %d %h", ctl, jmp, prv, ld, exis, f, exp_pm, exp_cau);
      if (n != 8) begin
        $display("malformed vector line: %s", line);
        errors++;
        continue;
      end
      @(negedge clk);
      // first line is the last reset cycle, the rest run after release
      if (cycles == 1) begin
        wait_reset();
      end
      {fetch_enable_i, instr_valid_i, illegal_insn_i, ecall_insn_i} = ctl[10:7];
      {ebrk_insn_i, mret_insn_i, fencei_insn_i, csr_status_i} = ctl[6:3];
      {branch_taken_ex_i, id_ready_i, ex_valid_i} = ctl[2:0];
      jump_in_dec_i   = jump_kind_e'(jmp[1:0]);
      priv_lvl_i      = priv_lvl_e'(prv[1:0]);
      data_req_ex_i   = ld[1];
      regfile_we_ex_i = ld[0];
      reg_d_ex_is_i   = exis;
      // outputs settle well before the next rising edge
      #4;
      check("instr_req_o", f[9], instr_req_o);
      check("first_fetch_o", f[8], first_fetch_o);
      check("pc_set_o", f[7], pc_set_o);
      check("halt_if_o", f[6], halt_if_o);
      check("halt_id_o", f[5], halt_id_o);
      check("csr_save_cause_o", f[4], csr_save_cause_o);
      check("csr_save_id_o", f[4], csr_save_id_o);
      check("csr_restore_mret_o", f[3], csr_restore_mret_o);
      check("load_stall_o", f[2], load_stall_o);
      check("jr_stall_o", f[1], jr_stall_o);
      check("deassert_we_o", f[0], deassert_we_o);
      check("ctrl_busy_o", 1, ctrl_busy_o);
      check("pc_mux_o", exp_pm, pc_mux_o);
      check("csr_cause_o", exp_cau, csr_cause_o);
      cycles++;
    end
    $fclose(fd);
  endtask

  ////////////////////
  // random forwarding sweep
  ////////////////////
  task automatic sweep_forwarding();
    logic [31:0] r;
    logic        wex, wwb, alu, wbr, drq, mis, mul, jalr;
    op_match_t   exis, wbis, aluis;
    fwd_sel_e    sel [3];
    logic        pend;
    logic        exp_ls;
    logic        exp_jr;
    for (int k = 0; k < SWEEP_N; k++) begin
      rnd_state = lcg_next(rnd_state);
      r = rnd_state;
      // upper lcg bits only, the low ones have short periods
      {wex, wwb, alu, wbr, drq, mis, mul, jalr} = r[31:24];
      exis  = r[23:21];
      wbis  = r[20:18];
      aluis = r[17:15];
      @(negedge clk);
      // fsm sits in decode with nothing valid, so nothing issues
      set_idle_inputs();
      {regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i, wb_ready_i} = {wex, wwb, alu, wbr};
      {data_req_ex_i, data_misaligned_i, mult_multicycle_i} = {drq, mis, mul};
      jump_in_dec_i  = jalr ? BRANCH_JALR : BRANCH_NONE;
      reg_d_ex_is_i  = exis;
      reg_d_wb_is_i  = wbis;
      reg_d_alu_is_i = aluis;
      // reference: load in ex or wb stalled holds a result back
      pend   = (drq & wex) | (~wbr & wwb);
      exp_ls = pend & (|exis);
      exp_jr = jalr & ((wwb & wbis[0]) | (wex & exis[0]) | (alu & aluis[0]));
      for (int i = 0; i < 3; i++) begin
        sel[i] = SEL_REGFILE;
        if (wwb && wbis[i]) begin
          sel[i] = SEL_FW_WB;
        end
        if (alu && aluis[i]) begin
          sel[i] = SEL_FW_EX;
        end
      end
      if (mis) begin
        sel[0] = SEL_FW_EX;
        sel[1] = SEL_REGFILE;
      end else if (mul) begin
        sel[2] = SEL_FW_EX;
      end
      #4;
      check("operand_a_fwd_o", sel[0], operand_a_fwd_o);
      check("operand_b_fwd_o", sel[1], operand_b_fwd_o);
      check("operand_c_fwd_o", sel[2], operand_c_fwd_o);
      check("misaligned_stall_o", mis, misaligned_stall_o);
      check("load_stall_o", exp_ls, load_stall_o);
      check("jr_stall_o", exp_jr, jr_stall_o);
      check("deassert_we_o", 1, deassert_we_o);
    end
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    timeouts  = 0;
    rnd_state = 32'h2098;
    set_idle_inputs();
    // replay begins one cycle before reset releases
    @(negedge clk);
    run_vectors();
    sweep_forwarding();
    finish_run();
  end

endmodule
